// ==== design/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// number of read ports into the cache core
`define DC_NUM_PORTS 3
// associativity
`define DC_WAYS 4
// set index width, 16 sets
`define DC_IDX_W 4
`define DC_TAG_W 8
`define DC_WORD_W 64

// words per line, one data bank per word
`define DC_BANKS 2
// byte offset width within a line
`define DC_OFF_W 4
// wide enough to name every read port
`define DC_PORT_W 2

`endif

// ==== design/dcache_pkg.sv ====
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

  typedef logic [`DC_PORT_W-1:0] port_idx_t;
  // word offset inside a line, selects the data bank
  typedef logic [$clog2(`DC_BANKS)-1:0] bank_idx_t;

  typedef struct packed {
    logic [`DC_IDX_W-1:0] idx;
    logic [`DC_OFF_W-1:0] off;
  } rd_port_t;

  typedef logic [`DC_BANKS-1:0][`DC_WORD_W-1:0] line_t;

  typedef struct packed {
    logic                 valid;
    logic [`DC_WAYS-1:0]  way_we;
    logic [`DC_TAG_W-1:0] tag;
    logic [`DC_IDX_W-1:0] idx;
    logic                 vld_bit;
    line_t                data;
  } line_wr_t;

  // word of the tag memories
  typedef struct packed {
    logic                 vld;
    logic [`DC_TAG_W-1:0] tag;
  } tag_entry_t;

  // one word per way, word of a data bank
  typedef logic [`DC_WAYS-1:0][`DC_WORD_W-1:0] bank_word_t;

  typedef struct packed {
    logic                 rd;
    port_idx_t            port;
    logic [`DC_IDX_W-1:0] idx;
    bank_idx_t            bank;
  } grant_t;

  typedef struct packed {
    logic [`DC_WAYS-1:0]   hit;
    logic [`DC_WAYS-1:0]   vld;
    logic [`DC_WORD_W-1:0] data;
  } rd_result_t;

endpackage

`default_nettype wire

// ==== design/dcache_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_sram #(
  parameter type         word_t   = logic [7:0],
  // independently writable lanes of equal width
  parameter int unsigned NumLanes = 1
) (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic [NumLanes-1:0]  we_i,
  input  logic [`DC_IDX_W-1:0] addr_i,
  input  word_t                wdata_i,
  output word_t                rdata_o
);

  localparam int unsigned WordW = $bits(word_t);
  localparam int unsigned LaneW = WordW / NumLanes;
  localparam int unsigned Depth = 1 << `DC_IDX_W;

  logic [WordW-1:0] mem [Depth];
  logic [WordW-1:0] wdata;

  assign wdata = wdata_i;

  // registered read, no read during write
  always_ff @(posedge clk_i) begin : p_mem
    if (req_i) begin
      if (|we_i) begin
        for (int unsigned l = 0; l < NumLanes; l++) begin
          if (we_i[l]) begin
            mem[addr_i][l*LaneW +: LaneW] <= wdata[l*LaneW +: LaneW];
          end
        end
      end else begin
        rdata_o <= word_t'(mem[addr_i]);
      end
    end
  end

  we_needs_req: assert property (@(posedge clk_i) |we_i |-> req_i)
    else $error("write enable without request");

endmodule

`default_nettype wire

// ==== design/dcache_port_arb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_port_arb import dcache_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  rd_port_t [`DC_NUM_PORTS-1:0] rd_port_i,
  input  logic [`DC_NUM_PORTS-1:0]     rd_req_i,
  input  logic [`DC_NUM_PORTS-1:0]     rd_prio_i,
  input  line_wr_t                     line_wr_i,
  output logic [`DC_NUM_PORTS-1:0]     rd_ack_o,
  output grant_t                       grant_o
);

  logic [`DC_NUM_PORTS-1:0] req_prio;
  logic [`DC_NUM_PORTS-1:0] req_masked;
  logic                     found;
  port_idx_t                sel;
  port_idx_t                rr_d;
  port_idx_t                rr_q;

  //////////////////////////////////////////////////////////////////////
  // priority masking and round robin
  //////////////////////////////////////////////////////////////////////

  // any high prio request hides all low prio ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  // first request at or after the pointer, wrapping around
  always_comb begin : p_search
    int unsigned p;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < `DC_NUM_PORTS; i++) begin
      p = (int'(rr_q) + i) % `DC_NUM_PORTS;
      if (!found && req_masked[p]) begin
        found = 1'b1;
        sel   = port_idx_t'(p);
      end
    end
  end

  // a refill stalls every read in its cycle
  always_comb begin : p_grant
    rd_ack_o      = '0;
    grant_o.rd    = found & ~line_wr_i.valid;
    grant_o.port  = sel;
    grant_o.idx   = rd_port_i[sel].idx;
    grant_o.bank  = rd_port_i[sel].off[`DC_OFF_W-1 -: $bits(bank_idx_t)];
    if (grant_o.rd) begin
      rd_ack_o[sel] = 1'b1;
    end
  end

  assign rr_d = (sel == port_idx_t'(`DC_NUM_PORTS - 1)) ? '0 : sel + port_idx_t'(1);

  // pointer only moves on a real grant
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (grant_o.rd) begin
      rr_q <= rr_d;
    end
  end

  // an unacknowledged request stays up in the next cycle
  req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ($past(rd_req_i & ~rd_ack_o) & ~rd_req_i) == '0)
    else $error("read request dropped before its acknowledge");

endmodule

`default_nettype wire

// ==== design/dcache_arrays.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_arrays import dcache_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  grant_t                     grant_i,
  input  line_wr_t                   line_wr_i,
  output tag_entry_t [`DC_WAYS-1:0]  tag_o,
  output bank_word_t                 bank_o,
  output logic                       cmp_en_o,
  output port_idx_t                  port_q_o
);

  logic [`DC_WAYS-1:0]          tag_req;
  logic [`DC_WAYS-1:0]          tag_we;
  tag_entry_t                   tag_wdata;
  logic [`DC_IDX_W-1:0]         addr;
  logic [`DC_BANKS-1:0]         bank_req;
  logic [`DC_WAYS-1:0]          bank_we;
  bank_word_t [`DC_BANKS-1:0]   bank_wdata;
  bank_word_t [`DC_BANKS-1:0]   bank_rdata;
  bank_idx_t                    bank_q;
  port_idx_t                    port_q;
  logic                         cmp_en_q;

  //////////////////////////////////////////////////////////////////////
  // memory enables
  //////////////////////////////////////////////////////////////////////

  // refill wins, the decode stage already holds reads off
  assign addr            = line_wr_i.valid ? line_wr_i.idx : grant_i.idx;
  assign tag_wdata.vld   = line_wr_i.vld_bit;
  assign tag_wdata.tag   = line_wr_i.tag;
  assign tag_req         = line_wr_i.valid ? line_wr_i.way_we : {`DC_WAYS{grant_i.rd}};
  assign tag_we          = line_wr_i.valid ? line_wr_i.way_we : '0;
  assign bank_we         = line_wr_i.valid ? line_wr_i.way_we : '0;

  always_comb begin : p_bank_req
    for (int unsigned k = 0; k < `DC_BANKS; k++) begin
      if (line_wr_i.valid) begin
        bank_req[k] = |line_wr_i.way_we;
      end else begin
        // only the addressed word offset is read
        bank_req[k] = grant_i.rd && (grant_i.bank == bank_idx_t'(k));
      end
      bank_wdata[k] = {`DC_WAYS{line_wr_i.data[k]}};
    end
  end

  for (genvar w = 0; w < `DC_WAYS; w++) begin : gen_tag
    dcache_sram #(
      .word_t (tag_entry_t)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .req_i   (tag_req[w]),
      .we_i    (tag_we[w]),
      .addr_i  (addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_o[w])
    );
  end

  // lane l of a bank word belongs to way l
  for (genvar k = 0; k < `DC_BANKS; k++) begin : gen_bank
    dcache_sram #(
      .word_t   (bank_word_t),
      .NumLanes (`DC_WAYS)
    ) i_bank_sram (
      .clk_i   (clk_i),
      .req_i   (bank_req[k]),
      .we_i    (bank_we),
      .addr_i  (addr),
      .wdata_i (bank_wdata[k]),
      .rdata_o (bank_rdata[k])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // request registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      bank_q   <= '0;
      port_q   <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      bank_q   <= grant_i.bank;
      port_q   <= grant_i.port;
      cmp_en_q <= grant_i.rd;
    end
  end

  assign bank_o   = bank_rdata[bank_q];
  assign cmp_en_o = cmp_en_q;
  assign port_q_o = port_q;

endmodule

`default_nettype wire

// ==== design/dcache_hit_sel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_hit_sel import dcache_pkg::*; (
  input  logic                                    clk_i,
  input  logic [`DC_NUM_PORTS-1:0][`DC_TAG_W-1:0] rd_tag_i,
  input  port_idx_t                               port_q_i,
  input  logic                                    cmp_en_i,
  input  tag_entry_t [`DC_WAYS-1:0]               tag_i,
  input  bank_word_t                              bank_i,
  output rd_result_t                              rd_result_o
);

  logic [`DC_TAG_W-1:0] rd_tag;

  // tag of the port granted last cycle
  assign rd_tag = rd_tag_i[port_q_i];

  always_comb begin : p_cmp
    for (int unsigned w = 0; w < `DC_WAYS; w++) begin
      rd_result_o.vld[w] = tag_i[w].vld;
      rd_result_o.hit[w] = cmp_en_i & tag_i[w].vld & (tag_i[w].tag == rd_tag);
    end
  end

  // walk down so the lowest hitting way is the last one taken
  always_comb begin : p_word_sel
    rd_result_o.data = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (rd_result_o.hit[w]) begin
        rd_result_o.data = bank_i[w];
      end
    end
  end

  // refills never place one tag in two ways of a set
  hit_onehot: assert property (@(posedge clk_i) $onehot0(rd_result_o.hit))
    else $error("hit vector is not one-hot");

endmodule

`default_nettype wire

// ==== design/dcache_mem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_mem_top import dcache_pkg::*; (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  rd_port_t [`DC_NUM_PORTS-1:0]            rd_port_i,
  input  logic [`DC_NUM_PORTS-1:0]                rd_req_i,
  input  logic [`DC_NUM_PORTS-1:0]                rd_prio_i,
  // tag arrives one cycle after the acknowledge
  input  logic [`DC_NUM_PORTS-1:0][`DC_TAG_W-1:0] rd_tag_i,
  input  line_wr_t                                line_wr_i,
  output logic [`DC_NUM_PORTS-1:0]                rd_ack_o,
  output rd_result_t                              rd_result_o
);

  grant_t                    grant;
  tag_entry_t [`DC_WAYS-1:0] tag;
  bank_word_t                bank;
  logic                      cmp_en;
  port_idx_t                 port_q;

  // decode stage
  dcache_port_arb i_port_arb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_port_i (rd_port_i),
    .rd_req_i  (rd_req_i),
    .rd_prio_i (rd_prio_i),
    .line_wr_i (line_wr_i),
    .rd_ack_o  (rd_ack_o),
    .grant_o   (grant)
  );

  // execute stage
  dcache_arrays i_arrays (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .grant_i   (grant),
    .line_wr_i (line_wr_i),
    .tag_o     (tag),
    .bank_o    (bank),
    .cmp_en_o  (cmp_en),
    .port_q_o  (port_q)
  );

  // result stage
  dcache_hit_sel i_hit_sel (
    .clk_i       (clk_i),
    .rd_tag_i    (rd_tag_i),
    .port_q_i    (port_q),
    .cmp_en_i    (cmp_en),
    .tag_i       (tag),
    .bank_i      (bank),
    .rd_result_o (rd_result_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_dcache_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache_mem import dcache_pkg::*; ();

  localparam int NP    = `DC_NUM_PORTS;
  localparam int WAYS  = `DC_WAYS;
  localparam int SETS  = 1 << `DC_IDX_W;
  localparam int NFILL = 12;
  // reset, sweep, round robin, fill, miss, invalidate, priority, stall
  localparam int TestCycles = 4 + 16 + 13 + 25 + 13 + 9 + 11 + 11;
  localparam int CycleLimit = 2 * TestCycles;

  typedef logic [`DC_IDX_W-1:0] idx_t;
  typedef logic [`DC_OFF_W-1:0] off_t;
  typedef logic [`DC_TAG_W-1:0] tag_t;

  typedef struct packed {
    logic     prio;
    tag_t     tag;
    rd_port_t addr;
  } req_item_t;

  logic                clk_i;
  logic                rst_ni;
  rd_port_t [NP-1:0]   rd_port_i;
  logic [NP-1:0]       rd_req_i;
  logic [NP-1:0]       rd_prio_i;
  tag_t [NP-1:0]       rd_tag_i;
  line_wr_t            line_wr_i;
  logic [NP-1:0]       rd_ack_o;
  rd_result_t          rd_result_o;

  // shadow copy of the cache contents
  tag_t                  sh_tag  [SETS][WAYS];
  logic                  sh_vld  [SETS][WAYS];
  logic [`DC_WORD_W-1:0] sh_data [SETS][WAYS][`DC_BANKS];

  req_item_t     pend_q [NP][$];
  int            ack_log [$];
  logic [NP-1:0] ack_seen = '0;
  int            rr_model = 0;
  logic          res_pend = 1'b0;
  rd_result_t    res_exp;
  logic [31:0]   lfsr_q = 32'h13ae_ed9a;
  int            errors = 0;
  int            checks = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  int            cycles = 0;
  idx_t          fill_idx [NFILL];
  tag_t          fill_tag [NFILL];
  logic [1:0]    fill_way [NFILL];

  dcache_mem_top UUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_port_i   (rd_port_i),
    .rd_req_i    (rd_req_i),
    .rd_prio_i   (rd_prio_i),
    .rd_tag_i    (rd_tag_i),
    .line_wr_i   (line_wr_i),
    .rd_ack_o    (rd_ack_o),
    .rd_result_o (rd_result_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles > CycleLimit) begin
      $display("timeout: still running after %0d cycles, reads never finished", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int b = 0; b < `DC_BANKS; b++) begin
      l[b][63:32] = rand_bits(32);
      l[b][31:0]  = rand_bits(32);
    end
    return l;
  endfunction

  function automatic int pending_reads();
    int n;
    n = 0;
    for (int p = 0; p < NP; p++) begin
      n += pend_q[p].size();
    end
    return n;
  endfunction

  // one clock cycle; acked requests leave their queue, heads are presented
  task automatic step(input line_wr_t wr);
    req_item_t head;
    @(negedge clk_i);
    for (int p = 0; p < NP; p++) begin
      if (ack_seen[p] === 1'b1 && pend_q[p].size() > 0) begin
        void'(pend_q[p].pop_front());
      end
      rd_req_i[p]  = 1'b0;
      rd_prio_i[p] = 1'b0;
      if (pend_q[p].size() > 0) begin
        head         = pend_q[p][0];
        rd_req_i[p]  = 1'b1;
        rd_prio_i[p] = head.prio;
        rd_port_i[p] = head.addr;
        rd_tag_i[p]  = head.tag;
      end
    end
    line_wr_i = wr;
  endtask

  task automatic refill(input idx_t idx, input logic [WAYS-1:0] ways, input tag_t tag,
                        input logic vld, input line_t data);
    line_wr_t wr;
    wr.valid   = 1'b1;
    wr.way_we  = ways;
    wr.tag     = tag;
    wr.idx     = idx;
    wr.vld_bit = vld;
    wr.data    = data;
    step(wr);
  endtask

  task automatic queue_read(input int port, input idx_t idx, input off_t off,
                            input tag_t tag, input logic prio);
    req_item_t item;
    item.prio     = prio;
    item.tag      = tag;
    item.addr.idx = idx;
    item.addr.off = off;
    pend_q[port].push_back(item);
  endtask

  task automatic drain();
    while (pending_reads() > 0) begin
      step('0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and compare process
  //////////////////////////////////////////////////////////////////////

  function automatic logic [NP-1:0] expected_ack(input logic [NP-1:0] req,
      input logic [NP-1:0] prio, input logic wr_valid, input int ptr);
    logic [NP-1:0] cand;
    logic [NP-1:0] ack;
    int            p;
    ack  = '0;
    cand = ((req & prio) != '0) ? (req & prio) : req;
    for (int i = 0; i < NP; i++) begin
      p = (ptr + i) % NP;
      if (ack == '0 && cand[p] && !wr_valid) begin
        ack[p] = 1'b1;
      end
    end
    return ack;
  endfunction

  function automatic rd_result_t expected_result(input rd_port_t addr, input tag_t tag);
    rd_result_t res;
    logic       bank;
    logic       found;
    res   = '0;
    found = 1'b0;
    // 8-byte words, so the top offset bit picks the word
    bank  = addr.off[`DC_OFF_W-1];
    for (int w = 0; w < WAYS; w++) begin
      res.vld[w] = sh_vld[addr.idx][w];
      res.hit[w] = sh_vld[addr.idx][w] && (sh_tag[addr.idx][w] == tag);
      if (res.hit[w] && !found) begin
        res.data = sh_data[addr.idx][w][bank];
        found    = 1'b1;
      end
    end
    return res;
  endfunction

  task automatic apply_refill(input line_wr_t wr);
    for (int w = 0; w < WAYS; w++) begin
      if (wr.way_we[w]) begin
        sh_tag[wr.idx][w] = wr.tag;
        sh_vld[wr.idx][w] = wr.vld_bit;
        for (int b = 0; b < `DC_BANKS; b++) begin
          sh_data[wr.idx][w][b] = wr.data[b];
        end
      end
    end
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("MISMATCH at %0t: %s got %h expected %h", $time, sig, got, exp);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic sample_ack();
    logic [NP-1:0] exp_ack;
    ack_seen = rd_ack_o;
    res_pend = 1'b0;
    if (rst_ni) begin
      exp_ack = expected_ack(rd_req_i, rd_prio_i, line_wr_i.valid, rr_model);
      checks++;
      if (rd_ack_o !== exp_ack) begin
        report_mismatch("rd_ack_o", 64'(rd_ack_o), 64'(exp_ack));
      end
      for (int p = 0; p < NP; p++) begin
        if (rd_ack_o[p] === 1'b1) begin
          ack_log.push_back(p);
        end
        if (exp_ack[p]) begin
          res_exp  = expected_result(rd_port_i[p], rd_tag_i[p]);
          res_pend = 1'b1;
          rr_model = (p + 1) % NP;
        end
      end
      if (line_wr_i.valid) begin
        apply_refill(line_wr_i);
      end
    end
  endtask

  task automatic check_result();
    checks++;
    if (res_pend) begin
      if (rd_result_o.hit !== res_exp.hit) begin
        report_mismatch("rd_result_o.hit", 64'(rd_result_o.hit), 64'(res_exp.hit));
      end
      if (rd_result_o.vld !== res_exp.vld) begin
        report_mismatch("rd_result_o.vld", 64'(rd_result_o.vld), 64'(res_exp.vld));
      end
      if (rd_result_o.data !== res_exp.data) begin
        report_mismatch("rd_result_o.data", rd_result_o.data, res_exp.data);
      end
    end else if (rd_result_o.hit !== '0) begin
      report_mismatch("rd_result_o.hit", 64'(rd_result_o.hit), 64'(0));
    end
  endtask

  // acks settle after the falling edge, results after the rising edge
  initial begin : compare
    forever begin
      @(negedge clk_i);
      #10;
      sample_ack();
      @(posedge clk_i);
      #10;
      check_result();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic round_robin_order();
    int e;
    e = errors;
    ack_log.delete();
    for (int i = 0; i < 4; i++) begin
      for (int p = 0; p < NP; p++) begin
        queue_read(p, idx_t'(i), off_t'(rand_bits(4)), tag_t'(rand_bits(8)), 1'b0);
      end
    end
    drain();
    checks++;
    if (ack_log.size() != 4 * NP) begin
      report_error("round robin gave the wrong number of acknowledges");
    end
    // pointer starts at port 0 after reset
    for (int k = 0; k < ack_log.size(); k++) begin
      if (ack_log[k] != k % NP) begin
        report_mismatch("acked port", 64'(ack_log[k]), 64'(k % NP));
      end
    end
    end_test("round_robin", e);
  endtask

  task automatic fill_and_hit();
    int e;
    e = errors;
    for (int i = 0; i < NFILL; i++) begin
      fill_idx[i] = idx_t'(rand_bits(4) % 12);
      fill_way[i] = 2'(rand_bits(2));
      // low nibble keeps every fill tag unique
      fill_tag[i] = {4'(rand_bits(4)), 4'(i)};
      refill(fill_idx[i], 4'(1 << fill_way[i]), fill_tag[i], 1'b1, random_line());
    end
    for (int i = 0; i < NFILL; i++) begin
      queue_read(int'(rand_bits(2) % NP), fill_idx[i], off_t'(rand_bits(4)), fill_tag[i], 1'b0);
    end
    drain();
    end_test("fill_hit", e);
  endtask

  task automatic miss_reads();
    int e;
    e = errors;
    for (int i = 0; i < 12; i++) begin
      if (i < 6) begin
        queue_read(i % NP, fill_idx[i], off_t'(rand_bits(4)), {4'(rand_bits(4)), 4'hf}, 1'b0);
      end else begin
        // sets 12 to 15 hold no valid line yet
        queue_read(i % NP, idx_t'(12 + i % 4), off_t'(rand_bits(4)), tag_t'(rand_bits(8)),
                   1'b0);
      end
    end
    drain();
    end_test("miss", e);
  endtask

  task automatic invalidate_lines();
    int e;
    e = errors;
    for (int i = 0; i < 4; i++) begin
      refill(fill_idx[i], 4'(1 << fill_way[i]), fill_tag[i], 1'b0, random_line());
    end
    for (int i = 0; i < 4; i++) begin
      queue_read(i % NP, fill_idx[i], off_t'(rand_bits(4)), fill_tag[i], 1'b0);
    end
    drain();
    end_test("invalidate", e);
  endtask

  task automatic priority_masking();
    int e;
    e = errors;
    ack_log.delete();
    for (int i = 0; i < 4; i++) begin
      queue_read(0, fill_idx[i], off_t'(rand_bits(4)), fill_tag[i], 1'b0);
    end
    for (int i = 0; i < 3; i++) begin
      queue_read(1, fill_idx[4 + i], off_t'(rand_bits(4)), fill_tag[4 + i], 1'b1);
      queue_read(2, fill_idx[8 + i], off_t'(rand_bits(4)), fill_tag[8 + i], 1'b1);
    end
    drain();
    for (int k = 0; k < 6 && k < ack_log.size(); k++) begin
      checks++;
      if (ack_log[k] == 0) begin
        report_error("low priority port 0 acked while high priority requests were waiting");
      end
    end
    end_test("priority", e);
  endtask

  task automatic refill_stall();
    int   e;
    tag_t stall_tag [3];
    e = errors;
    for (int i = 0; i < 3; i++) begin
      stall_tag[i] = {4'(rand_bits(4)), 4'(12 + i)};
      queue_read(i, idx_t'(12 + i), off_t'(rand_bits(4)), stall_tag[i], 1'b0);
      queue_read(i, idx_t'(12 + i), off_t'(rand_bits(4)), stall_tag[i], 1'b1);
    end
    ack_log.delete();
    // every port requests while the refills go in
    for (int i = 0; i < 3; i++) begin
      refill(idx_t'(12 + i), 4'(1 << rand_bits(2)), stall_tag[i], 1'b1, random_line());
    end
    step('0);
    checks++;
    if (ack_log.size() != 0) begin
      report_error("a read was acknowledged in a refill cycle");
    end
    drain();
    end_test("refill_stall", e);
  endtask

  initial begin : main
    int e;
    rst_ni    = 1'b0;
    rd_port_i = '0;
    rd_req_i  = '0;
    rd_prio_i = '0;
    rd_tag_i  = '0;
    line_wr_i = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // hit vector stays zero right after reset
    e = errors;
    repeat (3) step('0);
    end_test("reset", e);

    e = errors;
    for (int s = 0; s < SETS; s++) begin
      refill(idx_t'(s), '1, '0, 1'b0, '0);
    end
    end_test("sweep", e);

    round_robin_order();
    fill_and_hit();
    miss_reads();
    invalidate_lines();
    priority_masking();
    refill_stall();

    $display("%0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_sram.sv
design/dcache_port_arb.sv
design/dcache_arrays.sv
design/dcache_hit_sel.sv
design/dcache_mem_top.sv
test/tb_dcache_mem.sv

// ==== Makefile ====
SRCS = $(wildcard design/*.sv design/*.svh test/*.sv) list.f

run: obj_dir/Vtb_dcache_mem
	obj_dir/Vtb_dcache_mem | tee sim.log
	grep -q "Testbench passed" sim.log

obj_dir/Vtb_dcache_mem: $(SRCS)
	verilator --binary --assert -Wno-fatal -f list.f --top-module tb_dcache_mem

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
